//--- ipf_cfg.svh
`ifndef IPF_CFG_SVH
`define IPF_CFG_SVH

// block edge in pixels
`define IPF_BLOCK 16

// row and column counter width
`define IPF_BLOCK_LOG 4

// bits per pixel
`define IPF_PIX_W 8

// frame address width
`define IPF_ADDR_W 14

// block coordinate width
`define IPF_LCU_W 3

// frame width in pixels, eight blocks across
`define IPF_FRAME_W 128

// band count for band offset
// pixel value shifted down by three
`define IPF_BANDS 32

`endif

//--- ipf_pkg.sv
`include "ipf_cfg.svh"

package ipf_pkg;

    // filter type as sampled per block
    // type 3 behaves like off
    typedef enum logic [1:0] {
        mode_off  = 2'd0,
        mode_band = 2'd1,
        mode_edge = 2'd2,
        mode_pass = 2'd3
    } ipf_mode_t;

    // one pixel sample
    typedef logic [`IPF_PIX_W-1:0] pix_t;

    // four signed nibbles in one word
    // element 0 sits in the top nibble
    typedef logic [0:3][3:0] offset_set_t;

endpackage

//--- ipf_pixel_in.sv
`timescale 1ns/1ps
`include "ipf_cfg.svh"

module ipf_pixel_in (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_en,
    input  ipf_pkg::pix_t              din,
    input  logic [1:0]                 ipf_type,
    input  logic [4:0]                 ipf_band_pos,
    input  logic [15:0]                ipf_offset,
    input  logic [`IPF_LCU_W-1:0]      lcu_x,
    input  logic [`IPF_LCU_W-1:0]      lcu_y,
    output logic                       cen_valid,
    output logic                       cen_last,
    output ipf_pkg::pix_t              left_pix,
    output ipf_pkg::pix_t              cen_pix,
    output ipf_pkg::pix_t              right_pix,
    output ipf_pkg::ipf_mode_t         cen_mode,
    output logic [4:0]                 cen_band_pos,
    output ipf_pkg::offset_set_t       cen_offset,
    output logic [`IPF_BLOCK_LOG-1:0]  cen_row,
    output logic [`IPF_BLOCK_LOG-1:0]  cen_col,
    output logic [`IPF_LCU_W-1:0]      cen_lcu_x,
    output logic [`IPF_LCU_W-1:0]      cen_lcu_y
);

    localparam logic [`IPF_BLOCK_LOG-1:0] edge_idx = `IPF_BLOCK_LOG'(`IPF_BLOCK - 1);

    // raster position of the incoming pixel
    logic [`IPF_BLOCK_LOG-1:0] col;
    logic [`IPF_BLOCK_LOG-1:0] row;
    logic                      col_end;
    logic                      row_end;
    logic                      blk_first;

    // newest window slot with its side data
    logic                      new_valid;
    ipf_pkg::pix_t             new_pix;
    logic [`IPF_BLOCK_LOG-1:0] new_row;
    logic [`IPF_BLOCK_LOG-1:0] new_col;
    ipf_pkg::ipf_mode_t        new_mode;
    logic [4:0]                new_band_pos;
    ipf_pkg::offset_set_t      new_offset;
    logic [`IPF_LCU_W-1:0]     new_lcu_x;
    logic [`IPF_LCU_W-1:0]     new_lcu_y;

    assign col_end   = (col == edge_idx);
    assign row_end   = (row == edge_idx);
    assign blk_first = (col == '0) && (row == '0);

    // right neighbour is simply the newest slot
    assign right_pix = new_pix;

    // counters step once per input pixel
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col <= '0;
            row <= '0;
        end else if (in_en) begin
            col <= col_end ? '0 : col + 1'b1;
            if (col_end) begin
                row <= row_end ? '0 : row + 1'b1;
            end
        end
    end

    // valid and image end flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            new_valid <= 1'b0;
            cen_valid <= 1'b0;
            cen_last  <= 1'b0;
        end else begin
            new_valid <= in_en;
            cen_valid <= new_valid;
            // block end with no pixel behind it
            cen_last  <= new_valid && !in_en && (new_row == edge_idx) && (new_col == edge_idx);
        end
    end

    // newest slot loads on in_en only
    always_ff @(posedge clk) begin
        if (in_en) begin
            new_pix <= din;
            new_row <= row;
            new_col <= col;
            // block parameters held from the first pixel on
            if (blk_first) begin
                new_mode     <= ipf_pkg::ipf_mode_t'(ipf_type);
                new_band_pos <= ipf_band_pos;
                new_offset   <= ipf_offset;
                new_lcu_x    <= lcu_x;
                new_lcu_y    <= lcu_y;
            end
        end
    end

    // centre and left slots shift every clock
    always_ff @(posedge clk) begin
        left_pix     <= cen_pix;
        cen_pix      <= new_pix;
        cen_row      <= new_row;
        cen_col      <= new_col;
        cen_mode     <= new_mode;
        cen_band_pos <= new_band_pos;
        cen_offset   <= new_offset;
        cen_lcu_x    <= new_lcu_x;
        cen_lcu_y    <= new_lcu_y;
    end

endmodule

//--- ipf_offset_core.sv
`timescale 1ns/1ps
`include "ipf_cfg.svh"

module ipf_offset_core (
    input  ipf_pkg::pix_t              left_pix,
    input  ipf_pkg::pix_t              cen_pix,
    input  ipf_pkg::pix_t              right_pix,
    input  ipf_pkg::ipf_mode_t         cen_mode,
    input  logic [4:0]                 cen_band_pos,
    input  ipf_pkg::offset_set_t       cen_offset,
    input  logic [`IPF_BLOCK_LOG-1:0]  cen_col,
    output ipf_pkg::pix_t              filt_pix
);

    localparam logic [4:0] band_max = 5'(`IPF_BANDS - 1);
    localparam logic [`IPF_BLOCK_LOG-1:0] edge_idx = `IPF_BLOCK_LOG'(`IPF_BLOCK - 1);

    // one result per offset nibble
    ipf_pkg::pix_t add_out [4];

    // band offset
    logic [4:0]    pix_band;
    logic [4:0]    band_lo;
    logic [4:0]    band_hi;
    logic          band_hit;
    ipf_pkg::pix_t band_pix;

    // horizontal edge offset
    logic [`IPF_PIX_W:0] mid_sum;
    ipf_pkg::pix_t       mid;
    logic                below_nb;
    logic                above_nb;
    logic                below_mid;
    logic                above_mid;
    logic                side_col;
    ipf_pkg::pix_t       edge_pix;

    // pixel plus signed nibble, clamped to pixel range
    function automatic ipf_pkg::pix_t sat_add(ipf_pkg::pix_t pix, logic [3:0] off);
        logic signed [`IPF_PIX_W+1:0] sum;
        ipf_pkg::pix_t                res;
        sum = $signed({2'b00, pix}) + $signed({{(`IPF_PIX_W - 2){off[3]}}, off});
        // top bit set means below zero
        if (sum[`IPF_PIX_W+1]) begin
            res = '0;
        end else if (sum[`IPF_PIX_W]) begin
            res = '1;
        end else begin
            res = sum[`IPF_PIX_W-1:0];
        end
        return res;
    endfunction

    // four adders side by side
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            add_out[i] = sat_add(cen_pix, cen_offset[i]);
        end
    end

    // band of the centre pixel
    assign pix_band = cen_pix[`IPF_PIX_W-1:3];

    // neighbouring bands, clamped at the ends
    assign band_lo = (cen_band_pos == 5'd0) ? 5'd0 : cen_band_pos - 5'd1;
    assign band_hi = (cen_band_pos == band_max) ? band_max : cen_band_pos + 5'd1;

    assign band_hit = (pix_band == cen_band_pos) || (pix_band == band_lo) ||
                      (pix_band == band_hi);

    // protected bands pass, others pick by bits 4 and 3
    assign band_pix = band_hit ? cen_pix : add_out[cen_pix[4:3]];

    // rounded down average of the neighbours
    assign mid_sum = {1'b0, left_pix} + {1'b0, right_pix};
    assign mid     = mid_sum[`IPF_PIX_W:1];

    assign below_nb  = (cen_pix < left_pix) && (cen_pix < right_pix);
    assign above_nb  = (cen_pix > left_pix) && (cen_pix > right_pix);
    assign below_mid = (cen_pix < mid);
    assign above_mid = (cen_pix > mid);

    // no full neighbour pair at the block sides
    assign side_col = (cen_col == '0) || (cen_col == edge_idx);

    always_comb begin
        if (side_col) begin
            edge_pix = cen_pix;
        end else if (below_nb && below_mid) begin
            // local minimum
            edge_pix = add_out[0];
        end else if (above_nb && above_mid) begin
            // local maximum
            edge_pix = add_out[3];
        end else if (below_mid) begin
            edge_pix = add_out[1];
        end else if (above_mid) begin
            edge_pix = add_out[2];
        end else begin
            // flat against mid
            edge_pix = cen_pix;
        end
    end

    // mode select
    always_comb begin
        case (cen_mode)
            ipf_pkg::mode_band: filt_pix = band_pix;
            ipf_pkg::mode_edge: filt_pix = edge_pix;
            // off and pass
            default:            filt_pix = cen_pix;
        endcase
    end

endmodule

//--- ipf_out_stage.sv
`timescale 1ns/1ps
`include "ipf_cfg.svh"

module ipf_out_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cen_valid,
    input  logic                       cen_last,
    input  ipf_pkg::pix_t              filt_pix,
    input  logic [`IPF_BLOCK_LOG-1:0]  cen_row,
    input  logic [`IPF_BLOCK_LOG-1:0]  cen_col,
    input  logic [`IPF_LCU_W-1:0]      cen_lcu_x,
    input  logic [`IPF_LCU_W-1:0]      cen_lcu_y,
    output logic                       out_en,
    output ipf_pkg::pix_t              dout,
    output logic [`IPF_ADDR_W-1:0]     dout_addr,
    output logic                       finish
);

    // frame address of the centre pixel
    logic [`IPF_ADDR_W-1:0] addr_next;

    // image last pixel went out on the previous edge
    logic last_out;

    // block row stride, then pixel row stride, then block column
    assign addr_next = `IPF_ADDR_W'(cen_lcu_y * (`IPF_BLOCK * `IPF_FRAME_W) +
                                    cen_row * `IPF_FRAME_W +
                                    cen_lcu_x * `IPF_BLOCK +
                                    cen_col);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_en    <= 1'b0;
            dout      <= '0;
            dout_addr <= '0;
            last_out  <= 1'b0;
            finish    <= 1'b0;
        end else begin
            out_en   <= cen_valid;
            last_out <= cen_valid && cen_last;
            // sticky until reset
            finish   <= finish || last_out;
            // hold last beat while idle
            if (cen_valid) begin
                dout      <= filt_pix;
                dout_addr <= addr_next;
            end
        end
    end

endmodule

//--- ipf_top.sv
`timescale 1ns/1ps
`include "ipf_cfg.svh"

module ipf_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_en,
    input  ipf_pkg::pix_t           din,
    input  logic [1:0]              ipf_type,
    input  logic [4:0]              ipf_band_pos,
    input  logic [15:0]             ipf_offset,
    input  logic [`IPF_LCU_W-1:0]   lcu_x,
    input  logic [`IPF_LCU_W-1:0]   lcu_y,
    output logic                    out_en,
    output ipf_pkg::pix_t           dout,
    output logic [`IPF_ADDR_W-1:0]  dout_addr,
    output logic                    finish
);

    // centre slot and its neighbours
    logic                      cen_valid;
    logic                      cen_last;
    ipf_pkg::pix_t             left_pix;
    ipf_pkg::pix_t             cen_pix;
    ipf_pkg::pix_t             right_pix;
    ipf_pkg::ipf_mode_t        cen_mode;
    logic [4:0]                cen_band_pos;
    ipf_pkg::offset_set_t      cen_offset;
    logic [`IPF_BLOCK_LOG-1:0] cen_row;
    logic [`IPF_BLOCK_LOG-1:0] cen_col;
    logic [`IPF_LCU_W-1:0]     cen_lcu_x;
    logic [`IPF_LCU_W-1:0]     cen_lcu_y;

    // filtered centre pixel
    ipf_pkg::pix_t             filt_pix;

    // two cycles to the centre slot
    ipf_pixel_in u_pixel_in (
        .clk          (clk),
        .reset        (reset),
        .in_en        (in_en),
        .din          (din),
        .ipf_type     (ipf_type),
        .ipf_band_pos (ipf_band_pos),
        .ipf_offset   (ipf_offset),
        .lcu_x        (lcu_x),
        .lcu_y        (lcu_y),
        .cen_valid    (cen_valid),
        .cen_last     (cen_last),
        .left_pix     (left_pix),
        .cen_pix      (cen_pix),
        .right_pix    (right_pix),
        .cen_mode     (cen_mode),
        .cen_band_pos (cen_band_pos),
        .cen_offset   (cen_offset),
        .cen_row      (cen_row),
        .cen_col      (cen_col),
        .cen_lcu_x    (cen_lcu_x),
        .cen_lcu_y    (cen_lcu_y)
    );

    // combinational filter on the centre
    ipf_offset_core u_offset_core (
        .left_pix     (left_pix),
        .cen_pix      (cen_pix),
        .right_pix    (right_pix),
        .cen_mode     (cen_mode),
        .cen_band_pos (cen_band_pos),
        .cen_offset   (cen_offset),
        .cen_col      (cen_col),
        .filt_pix     (filt_pix)
    );

    // output register and frame address
    ipf_out_stage u_out_stage (
        .clk          (clk),
        .reset        (reset),
        .cen_valid    (cen_valid),
        .cen_last     (cen_last),
        .filt_pix     (filt_pix),
        .cen_row      (cen_row),
        .cen_col      (cen_col),
        .cen_lcu_x    (cen_lcu_x),
        .cen_lcu_y    (cen_lcu_y),
        .out_en       (out_en),
        .dout         (dout),
        .dout_addr    (dout_addr),
        .finish       (finish)
    );

endmodule

//--- tb_ipf.sv
`timescale 1ns/1ps
`include "ipf_cfg.svh"

module tb_ipf;

    localparam int blk_pix     = `IPF_BLOCK * `IPF_BLOCK;
    localparam int max_blks    = 8;
    localparam int rand_imgs   = 6;
    localparam int drain_limit = 16;
    localparam int fin_limit   = 16;

    logic                   clk;
    logic                   reset;
    logic                   in_en;
    ipf_pkg::pix_t          din;
    logic [1:0]             ipf_type;
    logic [4:0]             ipf_band_pos;
    logic [15:0]            ipf_offset;
    logic [`IPF_LCU_W-1:0]  lcu_x;
    logic [`IPF_LCU_W-1:0]  lcu_y;
    logic                   out_en;
    ipf_pkg::pix_t          dout;
    logic [`IPF_ADDR_W-1:0] dout_addr;
    logic                   finish;

    // current image, one entry per block
    int                    n_blks;
    logic [1:0]            blk_type [max_blks];
    logic [4:0]            blk_band [max_blks];
    logic [15:0]           blk_off  [max_blks];
    logic [`IPF_LCU_W-1:0] blk_x    [max_blks];
    logic [`IPF_LCU_W-1:0] blk_y    [max_blks];
    logic [7:0]            img_pix  [max_blks * blk_pix];

    // expected beats in output order
    logic [7:0]             exp_pix_q  [$];
    logic [`IPF_ADDR_W-1:0] exp_addr_q [$];
    int                     exp_edge_q [$];

    logic [31:0]            lfsr_state;
    int                     cyc;
    int                     last_edge;
    int                     beats;
    logic                   fin_seen;
    string                  test_name;
    logic [7:0]             mon_pix;
    logic [`IPF_ADDR_W-1:0] mon_addr;
    int                     mon_edge;
    int                     img;

    ipf_top dut (
        .clk          (clk),
        .reset        (reset),
        .in_en        (in_en),
        .din          (din),
        .ipf_type     (ipf_type),
        .ipf_band_pos (ipf_band_pos),
        .ipf_offset   (ipf_offset),
        .lcu_x        (lcu_x),
        .lcu_y        (lcu_y),
        .out_en       (out_en),
        .dout         (dout),
        .dout_addr    (dout_addr),
        .finish       (finish)
    );

    always #4 clk = ~clk;

    // edge counter, read before its update by every process
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic fail_now(string why);
        $display("%s in %s", why, test_name);
        stop_run();
    endtask

    task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    // galois form, taps x^32 x^22 x^2 x^1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    // any band position, zero and 31 included
    function automatic logic [4:0] rand_band();
        logic [31:0] v;
        v = rand_bits(5);
        return v[4:0];
    endfunction

    // nibble k of the offset word, k = 0 on top
    function automatic logic [3:0] nib(logic [15:0] w, int k);
        return w[15 - 4 * k -: 4];
    endfunction

    function automatic logic [7:0] sat_model(int p, logic [3:0] off);
        int s;
        s = p + int'($signed(off));
        if (s < 0) begin
            return 8'd0;
        end
        if (s > 255) begin
            return 8'd255;
        end
        return s[7:0];
    endfunction

    // reference filter for stream pixel i
    function automatic logic [7:0] model_pix(int i);
        int          b;
        int          c;
        int          p;
        int          l;
        int          r;
        int          mid;
        int          bp;
        int          band;
        logic [15:0] off;
        b   = i / blk_pix;
        c   = i % `IPF_BLOCK;
        p   = img_pix[i];
        bp  = blk_band[b];
        off = blk_off[b];
        case (blk_type[b])
            2'd1: begin
                band = p / 8;
                if (band == bp || band == ((bp == 1) ? 0 : bp - 1) ||
                    band == ((bp == 31) ? 31 : bp + 1)) begin
                    return p[7:0];
                end
                // bits 4 and 3 pick the nibble
                return sat_model(p, nib(off, band % 4));
            end
            2'd2: begin
                if (c == 0 || c == `IPF_BLOCK - 1) begin
                    return p[7:0];
                end
                l   = img_pix[i - 1];
                r   = img_pix[i + 1];
                mid = (l + r) / 2;
                if (p < l && p < r && p < mid) begin
                    return sat_model(p, nib(off, 0));
                end
                if (p > l && p > r && p > mid) begin
                    return sat_model(p, nib(off, 3));
                end
                if (p < mid) begin
                    return sat_model(p, nib(off, 1));
                end
                if (p > mid) begin
                    return sat_model(p, nib(off, 2));
                end
                return p[7:0];
            end
            default: return p[7:0];
        endcase
    endfunction

    function automatic logic [`IPF_ADDR_W-1:0] model_addr(int i);
        int b;
        int k;
        b = i / blk_pix;
        k = i % blk_pix;
        return blk_y[b] * `IPF_BLOCK * `IPF_FRAME_W + (k / `IPF_BLOCK) * `IPF_FRAME_W +
               blk_x[b] * `IPF_BLOCK + k % `IPF_BLOCK;
    endfunction

    task automatic set_block(int b, logic [1:0] t, logic [4:0] bp, logic [15:0] off,
                             logic [2:0] x, logic [2:0] y);
        blk_type[b] = t;
        blk_band[b] = bp;
        blk_off[b]  = off;
        blk_x[b]    = x;
        blk_y[b]    = y;
    endtask

    // kind 1 narrow range, kind 2 near 0 and 255, else full range
    task automatic fill_block(int b, int kind);
        int k;
        for (k = 0; k < blk_pix; k++) begin
            case (kind)
                1:       img_pix[b * blk_pix + k] = 8'd100 + rand_bits(2);
                2:       img_pix[b * blk_pix + k] = rand_bits(1) ? rand_bits(3) :
                                                    8'd255 - rand_bits(3);
                default: img_pix[b * blk_pix + k] = rand_bits(8);
            endcase
        end
    endtask

    task automatic rand_block(int b);
        set_block(b, rand_bits(2), rand_band(), rand_bits(16), rand_bits(3), rand_bits(3));
        fill_block(b, rand_bits(2));
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        in_en <= 1'b0;
        repeat (4) @(posedge clk);
        fin_seen = 1'b0;
        reset <= 1'b0;
        @(posedge clk);
        check_val("out_en after reset", 0, out_en);
        check_val("finish after reset", 0, finish);
        check_val("dout after reset", 0, dout);
        check_val("dout_addr after reset", 0, dout_addr);
    endtask

    task automatic drive_image();
        int i;
        int b;
        for (i = 0; i < n_blks * blk_pix; i++) begin
            b = i / blk_pix;
            in_en <= 1'b1;
            din   <= img_pix[i];
            if (i % blk_pix == 0) begin
                ipf_type     <= blk_type[b];
                ipf_band_pos <= blk_band[b];
                ipf_offset   <= blk_off[b];
                lcu_x        <= blk_x[b];
                lcu_y        <= blk_y[b];
            end else begin
                // noise between first pixels is never sampled
                ipf_type     <= rand_bits(2);
                ipf_band_pos <= rand_bits(5);
                ipf_offset   <= rand_bits(16);
                lcu_x        <= rand_bits(3);
                lcu_y        <= rand_bits(3);
            end
            // the DUT samples this pixel on the next edge
            exp_edge_q.push_back(cyc + 1);
            last_edge = cyc + 1;
            @(posedge clk);
        end
        in_en <= 1'b0;
        din   <= '0;
    endtask

    task automatic run_image();
        int i;
        int t;
        exp_pix_q.delete();
        exp_addr_q.delete();
        exp_edge_q.delete();
        for (i = 0; i < n_blks * blk_pix; i++) begin
            exp_pix_q.push_back(model_pix(i));
            exp_addr_q.push_back(model_addr(i));
        end
        apply_reset();
        beats = 0;
        drive_image();
        t = 0;
        while (exp_pix_q.size() != 0) begin
            if (t >= drain_limit) begin
                fail_now("output stalled with pixels still pending");
            end else begin
                @(posedge clk);
                t++;
            end
        end
        t = 0;
        while (!fin_seen) begin
            if (t >= fin_limit) begin
                fail_now("finish never rose after the last pixel");
            end else begin
                @(posedge clk);
                t++;
            end
        end
        check_val("beat count", n_blks * blk_pix, beats);
    endtask

    // output beats, sampled one edge after they were driven
    always @(posedge clk) begin
        if (out_en) begin
            if (exp_pix_q.size() == 0) begin
                fail_now("out_en high with no pixel expected");
            end else begin
                mon_pix  = exp_pix_q.pop_front();
                mon_addr = exp_addr_q.pop_front();
                mon_edge = exp_edge_q.pop_front();
                check_val("dout", mon_pix, dout);
                check_val("dout_addr", mon_addr, dout_addr);
                // high after the second edge, seen on the third
                check_val("out_en edge", mon_edge + 3, cyc);
                beats++;
            end
        end
    end

    always @(posedge clk) begin
        if (finish && !fin_seen) begin
            fin_seen = 1'b1;
            // one edge behind the last beat
            check_val("finish edge", last_edge + 4, cyc);
        end else if (fin_seen && !reset) begin
            // sticky until the next reset
            check_val("finish held", 1, finish);
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        in_en        = 1'b0;
        din          = '0;
        ipf_type     = '0;
        ipf_band_pos = '0;
        ipf_offset   = '0;
        lcu_x        = '0;
        lcu_y        = '0;
        lfsr_state   = 32'hfae6_3e81;
        cyc          = 0;
        fin_seen     = 1'b0;
        beats        = 0;
        @(posedge clk);

        test_name = "off_pass";
        n_blks    = 2;
        set_block(0, 2'd0, rand_band(), rand_bits(16), 3'd0, 3'd0);
        set_block(1, 2'd3, rand_band(), rand_bits(16), 3'd7, 3'd7);
        fill_block(0, 0);
        fill_block(1, 0);
        run_image();

        test_name = "band";
        n_blks    = 3;
        set_block(0, 2'd1, 5'd1, rand_bits(16), 3'd1, 3'd2);
        set_block(1, 2'd1, 5'd31, rand_bits(16), 3'd2, 3'd2);
        // lowest band position, nothing below it
        set_block(2, 2'd1, 5'd0, rand_bits(16), 3'd3, 3'd2);
        fill_block(0, 0);
        fill_block(1, 0);
        fill_block(2, 0);
        run_image();

        test_name = "edge";
        n_blks    = 3;
        set_block(0, 2'd2, rand_band(), rand_bits(16), 3'd4, 3'd5);
        set_block(1, 2'd2, rand_band(), rand_bits(16), 3'd5, 3'd5);
        // small range makes pixels equal to mid common
        set_block(2, 2'd2, rand_band(), rand_bits(16), 3'd6, 3'd5);
        fill_block(0, 0);
        fill_block(1, 0);
        fill_block(2, 1);
        run_image();

        test_name = "saturation";
        n_blks    = 2;
        // nibbles -8, +7, -8, +7 from the top
        set_block(0, 2'd1, 5'd16, 16'h8787, 3'd0, 3'd6);
        set_block(1, 2'd2, 5'd16, 16'h8787, 3'd1, 3'd6);
        fill_block(0, 2);
        fill_block(1, 2);
        run_image();

        test_name = "back_to_back";
        n_blks    = 4;
        set_block(0, 2'd1, rand_band(), rand_bits(16), 3'd0, 3'd1);
        set_block(1, 2'd2, rand_band(), rand_bits(16), 3'd1, 3'd1);
        set_block(2, 2'd0, rand_band(), rand_bits(16), 3'd2, 3'd1);
        set_block(3, 2'd2, rand_band(), rand_bits(16), 3'd3, 3'd1);
        fill_block(0, 0);
        fill_block(1, 2);
        fill_block(2, 0);
        fill_block(3, 1);
        run_image();

        test_name = "random";
        for (img = 0; img < rand_imgs; img++) begin
            n_blks = 1 + rand_bits(3);
            for (int b = 0; b < n_blks; b++) begin
                rand_block(b);
            end
            run_image();
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
ipf_pkg.sv
ipf_pixel_in.sv
ipf_offset_core.sv
ipf_out_stage.sv
ipf_top.sv
tb_ipf.sv

//--- Bender.yml
package:
  name: ipf

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ipf_pkg.sv
      - ipf_pixel_in.sv
      - ipf_offset_core.sv
      - ipf_out_stage.sv
      - ipf_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_ipf.sv
